//--- flist.f
src/rename_cfg_pkg.sv
src/rename_types_pkg.sv
src/map_table.sv
src/free_list.sv
src/rename_unit.sv
verif/rename_asserts.sv
verif/rename_checker.sv
verif/rename_tb.sv

//--- run.sh
#!/bin/sh
# build and run the rename stage testbench with Verilator
verilator --binary --timing --assert --timescale 1ns/1ps --top-module rename_tb \
    -f flist.f -o rename_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/rename_sim > sim.log 2>&1 \
    || { echo "simulation exited with an error, see sim.log"; exit 1; }
grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Testbench passed" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL"; exit 1; }

//--- src/free_list.sv
// circular queue of free physical tags with speculative and committed heads, used by rename_unit
`default_nettype none

module free_list
    import rename_cfg_pkg::*;
#(
    parameter int num_arch_regs = num_arch_regs_default,
    parameter int num_phys_regs = num_phys_regs_default
) (
    input  logic                  clk,
    input  logic                  reset,
    // allocate head_tag, only when not empty
    input  logic                  pop,
    // return a tag freed by retire
    input  logic                  push,
    input  logic [phys_idx_w-1:0] push_tag,
    // rewind speculative head to committed head
    input  logic                  restore,
    output logic [phys_idx_w-1:0] head_tag,
    output logic                  empty
);

    // tags not held by the committed map
    localparam int depth = num_phys_regs - num_arch_regs;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_w = $clog2(depth + 1);

    logic [phys_idx_w-1:0] tags [depth];

    // next tag to hand out
    logic [ptr_w-1:0] spec_head;
    // head as seen by retired instructions only
    logic [ptr_w-1:0] commit_head;
    // next slot for a freed tag
    logic [ptr_w-1:0] tail;
    // free tags between spec_head and tail
    logic [count_w-1:0] count;

    logic [ptr_w-1:0] commit_head_next;

    // pointer increment with wrap, depth need not be a power of two
    function automatic logic [ptr_w-1:0] advance(input logic [ptr_w-1:0] ptr);
        logic [ptr_w-1:0] next;
        if (ptr == ptr_w'(depth - 1)) begin
            next = '0;
        end else begin
            next = ptr + ptr_w'(1);
        end
        return next;
    endfunction

    // every push retires one allocation, so committed head moves with it
    assign commit_head_next = push ? advance(commit_head) : commit_head;

    // queue storage
    // reset loads the tags above the identity mapping
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < depth; i++) begin
                tags[i] <= phys_idx_w'(num_arch_regs + i);
            end
        end else if (push) begin
            tags[tail] <= push_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            spec_head <= '0;
            commit_head <= '0;
            tail <= '0;
            count <= count_w'(depth);
        end else begin
            commit_head <= commit_head_next;
            if (push) begin
                tail <= advance(tail);
            end
            if (restore) begin
                // committed map always holds num_arch_regs tags
                // so the committed free count is always depth
                spec_head <= commit_head_next;
                count <= count_w'(depth);
            end else begin
                if (pop) begin
                    spec_head <= advance(spec_head);
                end
                count <= count + count_w'(push) - count_w'(pop);
            end
        end
    end

    assign head_tag = tags[spec_head];

    // head meets tail both when full and when empty, count tells them apart
    assign empty = (spec_head == tail) && (count == '0);

endmodule

`default_nettype wire

//--- src/map_table.sv
// speculative and retired register maps of the rename stage, instantiated inside rename_unit
`default_nettype none

module map_table
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;
#(
    parameter int num_arch_regs = num_arch_regs_default
) (
    input  logic      clk,
    input  logic      reset,
    // source and destination indices of the instruction in rename
    input  arch_idx_t rs1_idx,
    input  arch_idx_t rs2_idx,
    input  arch_idx_t rd_idx,
    // write new_dest into rd, only on a fired rename with rd != 0
    input  logic      dest_write,
    input  phys_tag_t new_dest,
    // source lookups with CDB forwarding
    output preg_t     rs1_preg,
    output preg_t     rs2_preg,
    // mapping of rd before this rename
    output preg_t     old_dest,
    input  cdb_t      cdb,
    input  retire_t   retire,
    // mispredict recovery
    input  logic      restore
);

    // speculative map, updated at rename
    preg_t spec_map [num_arch_regs];

    // retired map, holds committed state only
    preg_t arch_map [num_arch_regs];

    // retired map including this cycle's retire
    preg_t arch_map_next [num_arch_regs];

    logic retire_write;

    // identity mapping after reset
    function automatic preg_t reset_entry(input int idx);
        preg_t entry;
        entry.tag = phys_idx_w'(idx);
        entry.ready = 1'b1;
        return entry;
    endfunction

    // lookup of one map entry as seen by the requester
    // register 0 is hardwired, a matching CDB makes the entry ready now
    function automatic preg_t read_entry(
        input arch_idx_t idx,
        input preg_t     entry,
        input cdb_t      bus
    );
        preg_t result;
        result = entry;
        if (idx == zero_reg) begin
            result.tag = zero_tag;
            result.ready = 1'b1;
        end else if (bus.valid && (bus.tag == entry.tag)) begin
            result.ready = 1'b1;
        end
        return result;
    endfunction

    // read ports
    // all see the map before this cycle's update
    assign rs1_preg = read_entry(rs1_idx, spec_map[rs1_idx], cdb);
    assign rs2_preg = read_entry(rs2_idx, spec_map[rs2_idx], cdb);
    assign old_dest = read_entry(rd_idx, spec_map[rd_idx], cdb);

    // retiring register 0 changes nothing
    assign retire_write = retire.valid && (retire.rd != zero_reg);

    // committed map after this edge
    // restore reads this so a same-cycle retire is not lost
    always_comb begin
        arch_map_next = arch_map;
        if (retire_write) begin
            arch_map_next[retire.rd].tag = retire.dest_tag;
            arch_map_next[retire.rd].ready = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_arch_regs; i++) begin
                arch_map[i] <= reset_entry(i);
            end
        end else begin
            arch_map <= arch_map_next;
        end
    end

    // speculative map update
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < num_arch_regs; i++) begin
                spec_map[i] <= reset_entry(i);
            end
        end else if (restore) begin
            // throw away speculative state
            // committed values are all written back, so all ready
            for (int i = 0; i < num_arch_regs; i++) begin
                spec_map[i].tag <= arch_map_next[i].tag;
                spec_map[i].ready <= 1'b1;
            end
        end else begin
            // wake every entry holding the broadcast tag
            // entry 0 stays fixed
            for (int i = 1; i < num_arch_regs; i++) begin
                if (cdb.valid && (spec_map[i].tag == cdb.tag)) begin
                    spec_map[i].ready <= 1'b1;
                end
            end
            // rename write comes last
            // a CDB hit on the same entry loses, the new tag is not ready
            if (dest_write && (rd_idx != zero_reg)) begin
                spec_map[rd_idx].tag <= new_dest;
                spec_map[rd_idx].ready <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- src/rename_cfg_pkg.sv
// register counts and index widths for the rename stage, imported by the RTL and the testbench
`default_nettype none

package rename_cfg_pkg;

    // width of an architectural register index
    // 5 bits covers the 32 integer registers
    localparam int arch_idx_w = 5;

    // width of a physical register tag
    // 6 bits covers up to 64 physical registers
    localparam int phys_idx_w = 6;

    // register counts the top level passes down by default
    localparam int num_arch_regs_default = 32;
    localparam int num_phys_regs_default = 64;

    // physical registers in flight or free
    // the free list holds num_phys_regs - num_arch_regs tags

    // architectural register 0 always reads as zero
    localparam logic [arch_idx_w-1:0] zero_reg = '0;

    // physical register 0 backs architectural register 0
    // it is never allocated and never freed
    localparam logic [phys_idx_w-1:0] zero_tag = '0;

    // after reset arch reg i maps to phys reg i
    // phys regs num_arch_regs and up start on the free list
    // so the first allocation returns tag num_arch_regs

    // widths must hold the configured counts
    // num_arch_regs <= 2**arch_idx_w
    // num_phys_regs <= 2**phys_idx_w

endpackage

`default_nettype wire

//--- src/rename_types_pkg.sv
// struct types on the rename stage ports, shared by the map table, the top level and the testbench
`default_nettype none

package rename_types_pkg;

    import rename_cfg_pkg::*;

    // architectural register index
    typedef logic [arch_idx_w-1:0] arch_idx_t;

    // physical register tag
    typedef logic [phys_idx_w-1:0] phys_tag_t;

    // one map entry, physical tag plus ready bit
    typedef struct packed {
        phys_tag_t tag;
        logic      ready;
    } preg_t;

    // one instruction to rename
    typedef struct packed {
        arch_idx_t rs1;
        arch_idx_t rs2;
        arch_idx_t rd;
    } rename_req_t;

    // rename result, combinational from the request
    // new_dest is tag 0 when rd is register 0
    typedef struct packed {
        preg_t     rs1;
        preg_t     rs2;
        phys_tag_t new_dest;
        preg_t     old_dest;
    } rename_rsp_t;

    // common data bus broadcast, marks one tag ready
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } cdb_t;

    // retiring instruction
    // dest_tag becomes committed, old_tag goes back to the free list
    typedef struct packed {
        logic      valid;
        arch_idx_t rd;
        phys_tag_t dest_tag;
        phys_tag_t old_tag;
    } retire_t;

endpackage

`default_nettype wire

//--- src/rename_unit.sv
// top level of the rename stage, joins map table and free list and owns the rename handshake
`default_nettype none

module rename_unit
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;
#(
    parameter int num_arch_regs = num_arch_regs_default,
    parameter int num_phys_regs = num_phys_regs_default
) (
    input  logic        clk,
    input  logic        reset,
    // rename handshake, req held until accepted
    input  logic        req_valid,
    input  rename_req_t req,
    output logic        req_ready,
    // valid whenever req_valid is high
    output rename_rsp_t rsp,
    input  cdb_t        cdb,
    input  retire_t     retire,
    input  logic        restore
);

    // low through reset, high from the first cycle after it
    logic      running;
    logic      fire;
    // rename that takes a free tag
    logic      alloc;
    // retire that hands back a tag
    logic      free_old;
    logic      list_empty;
    phys_tag_t head_tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    // no rename while restoring or out of tags
    assign req_ready = running && !restore && !list_empty;
    assign fire = req_valid && req_ready;

    // rd of register 0 allocates nothing
    assign alloc = fire && (req.rd != zero_reg);
    assign free_old = retire.valid && (retire.rd != zero_reg);

    map_table #(
        .num_arch_regs(num_arch_regs)
    ) map_table_inst (
        .clk       (clk),
        .reset     (reset),
        .rs1_idx   (req.rs1),
        .rs2_idx   (req.rs2),
        .rd_idx    (req.rd),
        .dest_write(alloc),
        .new_dest  (head_tag),
        .rs1_preg  (rsp.rs1),
        .rs2_preg  (rsp.rs2),
        .old_dest  (rsp.old_dest),
        .cdb       (cdb),
        .retire    (retire),
        .restore   (restore)
    );

    free_list #(
        .num_arch_regs(num_arch_regs),
        .num_phys_regs(num_phys_regs)
    ) free_list_inst (
        .clk     (clk),
        .reset   (reset),
        .pop     (alloc),
        .push    (free_old),
        .push_tag(retire.old_tag),
        .restore (restore),
        .head_tag(head_tag),
        .empty   (list_empty)
    );

    // head of the free list is the tag this rename would take
    assign rsp.new_dest = (req.rd == zero_reg) ? zero_tag : head_tag;

endmodule

`default_nettype wire

//--- verif/rename_asserts.sv
// concurrent assertions bound into rename_unit, on the handshake and on free list use
`default_nettype none

module rename_asserts (
    input logic clk,
    input logic reset,
    input logic req_ready,
    input logic restore,
    input logic rs1_ready,
    input logic pop,
    input logic empty
);
    timeunit 1ns;
    timeprecision 1ps;

    // no rename can fire in a restore cycle
    assert property (@(posedge clk) disable iff (reset) restore |-> !req_ready)
        else $error("req_ready high during a restore cycle");

    // map entries all come out of reset defined
    assert property (@(posedge clk) disable iff (reset) !$isunknown(rs1_ready))
        else $error("rs1 ready bit unknown after reset");

    // allocation only from a non-empty list
    assert property (@(posedge clk) disable iff (reset) pop |-> !empty)
        else $error("free list popped while empty");

endmodule

`default_nettype wire

//--- verif/rename_checker.sv
// checker for the rename testbench, compares DUT outputs with the expected row at each falling edge
`default_nettype none

module rename_checker
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;
(
    input  logic        clk,
    input  logic        check_en,
    input  logic [3:0]  test_id,
    input  logic        last_row,
    input  logic        exp_ready,
    input  logic        check_rsp,
    input  rename_rsp_t exp_rsp,
    input  logic        req_ready,
    input  rename_rsp_t rsp,
    output int          error_count,
    output int          tests_run,
    output int          tests_failed
);
    timeunit 1ns;
    timeprecision 1ps;

    // mismatches in the test now running
    int test_errors;

    initial begin
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        test_errors = 0;
    end

    task automatic compare(input string name, input int got, input int want);
        if (got != want) begin
            $display("ERROR at %0t ns: %s got %0d expected %0d", $time, name, got, want);
            error_count++;
            test_errors++;
        end
    endtask

    // outputs settle half a cycle after the rising edge drive
    always @(negedge clk) begin
        if (check_en) begin
            compare("req_ready", int'(req_ready), int'(exp_ready));
            // rsp only means something while req_valid is high
            if (check_rsp) begin
                compare("rsp.rs1.tag", int'(rsp.rs1.tag), int'(exp_rsp.rs1.tag));
                compare("rsp.rs1.ready", int'(rsp.rs1.ready), int'(exp_rsp.rs1.ready));
                compare("rsp.rs2.tag", int'(rsp.rs2.tag), int'(exp_rsp.rs2.tag));
                compare("rsp.rs2.ready", int'(rsp.rs2.ready), int'(exp_rsp.rs2.ready));
                compare("rsp.new_dest", int'(rsp.new_dest), int'(exp_rsp.new_dest));
                compare("rsp.old_dest.tag", int'(rsp.old_dest.tag), int'(exp_rsp.old_dest.tag));
                compare("rsp.old_dest.ready", int'(rsp.old_dest.ready),
                        int'(exp_rsp.old_dest.ready));
            end
            if (last_row) begin
                tests_run++;
                if (test_errors != 0) begin
                    tests_failed++;
                end
                $display("test %0d done: %s, %0d mismatches", test_id,
                         (test_errors == 0) ? "ok" : "FAILED", test_errors);
                test_errors = 0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/rename_tb.sv
// testbench top for the rename stage, drives a table of rows into rename_unit and prints the result
`default_nettype none

module rename_tb
    import rename_cfg_pkg::*;
    import rename_types_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    // one table row, stimulus then expected values
    typedef struct packed {
        logic        req_valid;
        rename_req_t req;
        cdb_t        cdb;
        retire_t     retire;
        logic        restore;
        logic        exp_ready;
        logic        check_rsp;
        rename_rsp_t exp_rsp;
        logic [3:0]  test_id;
        logic        last;
    } row_t;

    logic        clk;
    logic        reset;
    logic        req_valid;
    rename_req_t req;
    logic        req_ready;
    rename_rsp_t rsp;
    cdb_t        cdb;
    retire_t     retire;
    logic        restore;

    // expected side, driven with the stimulus
    logic        check_en;
    logic        exp_ready;
    logic        check_rsp;
    rename_rsp_t exp_rsp;
    logic [3:0]  test_id;
    logic        last_row;

    int   error_count;
    int   tests_run;
    int   tests_failed;
    row_t table_q[$];
    row_t cur;
    logic table_built;

    rename_unit #(
        .num_arch_regs(num_arch_regs_default),
        .num_phys_regs(num_phys_regs_default)
    ) rename_unit_inst (
        .clk      (clk),
        .reset    (reset),
        .req_valid(req_valid),
        .req      (req),
        .req_ready(req_ready),
        .rsp      (rsp),
        .cdb      (cdb),
        .retire   (retire),
        .restore  (restore)
    );

    rename_checker checker_inst (
        .clk         (clk),
        .check_en    (check_en),
        .test_id     (test_id),
        .last_row    (last_row),
        .exp_ready   (exp_ready),
        .check_rsp   (check_rsp),
        .exp_rsp     (exp_rsp),
        .req_ready   (req_ready),
        .rsp         (rsp),
        .error_count (error_count),
        .tests_run   (tests_run),
        .tests_failed(tests_failed)
    );

    bind rename_unit rename_asserts asserts_inst (
        .clk      (clk),
        .reset    (reset),
        .req_ready(req_ready),
        .restore  (restore),
        .rs1_ready(rsp.rs1.ready),
        .pop      (alloc),
        .empty    (list_empty)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // blank row, no request, ready expected high
    task automatic new_row(input int test);
        cur = '0;
        cur.exp_ready = 1'b1;
        cur.test_id = 4'(test);
    endtask

    task automatic request(input arch_idx_t rs1, input arch_idx_t rs2, input arch_idx_t rd);
        cur.req_valid = 1'b1;
        cur.req.rs1 = rs1;
        cur.req.rs2 = rs2;
        cur.req.rd = rd;
    endtask

    task automatic expect_rsp(
        input phys_tag_t t1, input logic r1,
        input phys_tag_t t2, input logic r2,
        input phys_tag_t nd,
        input phys_tag_t ot, input logic ordy
    );
        cur.check_rsp = 1'b1;
        cur.exp_rsp.rs1 = '{tag: t1, ready: r1};
        cur.exp_rsp.rs2 = '{tag: t2, ready: r2};
        cur.exp_rsp.new_dest = nd;
        cur.exp_rsp.old_dest = '{tag: ot, ready: ordy};
    endtask

    // fresh row with a request and its full expected response
    task automatic request_row(
        input int        test,
        input arch_idx_t rs1, input arch_idx_t rs2, input arch_idx_t rd,
        input phys_tag_t t1, input logic r1,
        input phys_tag_t t2, input logic r2,
        input phys_tag_t nd,
        input phys_tag_t ot, input logic ordy
    );
        new_row(test);
        request(rs1, rs2, rd);
        expect_rsp(t1, r1, t2, r2, nd, ot, ordy);
    endtask

    task automatic push_row(input logic last);
        cur.last = last;
        table_q.push_back(cur);
    endtask

    task automatic build_table();
        int rd;
        phys_tag_t nd;
        phys_tag_t ot;
        logic ordy;
        // test 1, identity map, two registers per row
        for (int k = 0; k < num_arch_regs_default; k += 2) begin
            request_row(1, arch_idx_t'(k), arch_idx_t'(k + 1), 0,
                        phys_tag_t'(k), 1, phys_tag_t'(k + 1), 1, 0, 0, 1);
            push_row(0);
        end
        // register 0 stays fixed across renames of rd 0
        request_row(1, 5, 31, 0, 5, 1, 31, 1, 0, 0, 1);
        push_row(0);
        request_row(1, 0, 1, 0, 0, 1, 1, 1, 0, 0, 1);
        push_row(0);
        request_row(1, 0, 0, 0, 0, 1, 0, 1, 0, 0, 1);
        push_row(1);
        // test 2, tags come off the free list in order
        request_row(2, 1, 2, 3, 1, 1, 2, 1, 32, 3, 1);
        push_row(0);
        request_row(2, 3, 3, 3, 32, 0, 32, 0, 33, 32, 0);
        push_row(0);
        request_row(2, 3, 4, 4, 33, 0, 4, 1, 34, 4, 1);
        push_row(0);
        new_row(2);
        push_row(0);
        request_row(2, 4, 3, 0, 34, 0, 33, 0, 0, 0, 1);
        push_row(1);
        // test 3, CDB forwarding, then a wakeup lost to an overwrite of rd 4
        request_row(3, 3, 4, 0, 33, 1, 34, 0, 0, 0, 1);
        cur.cdb = '{valid: 1'b1, tag: 33};
        push_row(0);
        request_row(3, 3, 4, 4, 33, 1, 34, 1, 35, 34, 1);
        cur.cdb = '{valid: 1'b1, tag: 34};
        push_row(0);
        request_row(3, 4, 3, 0, 35, 0, 33, 1, 0, 0, 1);
        push_row(1);
        // test 4, retire first rename of rd 3, then restore
        request_row(4, 3, 4, 6, 33, 1, 35, 0, 36, 6, 1);
        cur.retire = '{valid: 1'b1, rd: 3, dest_tag: 32, old_tag: 3};
        push_row(0);
        request_row(4, 3, 6, 7, 33, 1, 36, 0, 37, 7, 1);
        cur.restore = 1'b1;
        cur.exp_ready = 1'b0;
        push_row(0);
        // 33 was never retired, so it comes back first
        request_row(4, 3, 6, 4, 32, 1, 6, 1, 33, 4, 1);
        push_row(1);
        // test 5, restore to a full free list then drain it
        new_row(5);
        cur.restore = 1'b1;
        cur.exp_ready = 1'b0;
        push_row(0);
        for (int k = 0; k < 32; k++) begin
            rd = (k < 31) ? k + 1 : 1;
            nd = (k < 31) ? phys_tag_t'(33 + k) : phys_tag_t'(3);
            ot = (k == 31) ? phys_tag_t'(33) : ((rd == 3) ? phys_tag_t'(32) : phys_tag_t'(rd));
            ordy = (k != 31);
            request_row(5, arch_idx_t'(rd), 0, arch_idx_t'(rd), ot, ordy, 0, 1, nd, ot, ordy);
            push_row(0);
        end
        // empty, request held
        new_row(5);
        request(1, 0, 5);
        cur.exp_ready = 1'b0;
        push_row(0);
        new_row(5);
        request(1, 0, 5);
        cur.exp_ready = 1'b0;
        cur.retire = '{valid: 1'b1, rd: 1, dest_tag: 33, old_tag: 1};
        push_row(0);
        // freed tag 1 is the only one left
        request_row(5, 1, 0, 5, 3, 0, 0, 1, 1, 37, 0);
        push_row(0);
        new_row(5);
        request(2, 0, 6);
        cur.exp_ready = 1'b0;
        push_row(1);
    endtask

    task automatic drive_row(input row_t r, input logic en);
        req_valid <= r.req_valid;
        req <= r.req;
        cdb <= r.cdb;
        retire <= r.retire;
        restore <= r.restore;
        check_en <= en;
        exp_ready <= r.exp_ready;
        check_rsp <= r.check_rsp;
        exp_rsp <= r.exp_rsp;
        test_id <= r.test_id;
        last_row <= r.last;
    endtask

    // watchdog, rows plus reset plus margin at 4 ns each
    initial begin
        int limit_ns;
        wait (table_built === 1'b1);
        limit_ns = (table_q.size() + 16 + 8) * 4 + 200;
        #(limit_ns);
        $display("watchdog expired after %0d ns, table did not finish", limit_ns);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        table_built = 1'b0;
        reset = 1'b1;
        req_valid = 1'b0;
        req = '0;
        cdb = '0;
        retire = '0;
        restore = 1'b0;
        check_en = 1'b0;
        exp_ready = 1'b0;
        check_rsp = 1'b0;
        exp_rsp = '0;
        test_id = '0;
        last_row = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        foreach (table_q[i]) begin
            @(posedge clk);
            drive_row(table_q[i], 1'b1);
        end
        @(posedge clk);
        drive_row('0, 1'b0);
        @(negedge clk);
        $display("summary: %0d tests, %0d failed, %0d mismatches",
                 tests_run, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_run == 5) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
